// File: tb.f
link_pkg.sv
link_regif.sv
link_regs.sv
link_txcrdt.sv
link_ctrl_top.sv
tb_link_ctrl.sv

// File: Makefile
# Verilator build and run of the link control testbench

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_link_ctrl \
		-f tb.f -Mdir obj_dir

run: compile
	./obj_dir/Vtb_link_ctrl > sim.log 2>&1 || true
	@cat sim.log
	@if grep -q "sim failed" sim.log; then echo "FAIL"; exit 1; fi
	@if ! grep -q "sim passed" sim.log; then echo "FAIL: no result in log"; exit 1; fi
	@echo "PASS"

clean:
	rm -rf obj_dir sim.log

// File: tb_link_ctrl.sv
`timescale 1ns/1ps
// self-checking testbench for link_ctrl_top, one outstanding request at a time
// needs timing and concurrent assertion support in the simulator

module tb_link_ctrl;

   localparam int CLK_PERIOD   = 4;
   localparam int WAIT_LIMIT   = 64;    // cycles allowed per handshake wait
   // run length estimate, about 30 requests plus timer and link-up waits
   localparam int REQUESTS     = 30;
   localparam int REQ_CYCLES   = 12;    // worst case with back-pressure
   localparam int OTHER_CYCLES = 140;
   localparam int MARGIN       = 10;
   localparam int WATCHDOG_NS  = (REQUESTS * REQ_CYCLES + OTHER_CYCLES) * MARGIN * CLK_PERIOD;
   localparam link_pkg::crdt_t K_INTRVL = 16'd5;

   logic clk, nreset, devicemode, deviceready, phy_linkactive;
   logic req_valid, req_ready, resp_valid, resp_ready;
   logic host_linkactive, csr_txen, csr_txcrdt_en, csr_rxen, crdt_update;
   logic [1:0]      csr_arbmode;
   link_pkg::cmd_t  req_cmd, resp_cmd;
   link_pkg::addr_t req_dstaddr, req_srcaddr, resp_dstaddr, resp_srcaddr;
   link_pkg::data_t req_data, resp_data;
   link_pkg::iow_t  phy_iow, csr_txiowidth, csr_rxiowidth;
   link_pkg::crdt_t csr_txcrdt_intrvl, csr_rxcrdt_req_init, csr_rxcrdt_resp_init;

   int              errors = 0;
   int              checks = 0;
   int              tests = 0;
   int              checks_at = 0;
   int              errors_at = 0;
   int              seed = 32'h63f8bde4;
   int              cycle = 0;         // negedge count
   int              pulses = 0;        // crdt_update pulses seen
   int              last_pulse = 0;
   int              gap = 0;           // cycles between last two pulses
   logic [31:0]     tag = 32'h0;       // request tag, also source address

   link_ctrl_top i_link_ctrl_top (.*);

   initial
   begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   //######################################################################
   // protocol checks
   //######################################################################
   resp_hold: assert property (@(posedge clk) disable iff (!nreset)
      resp_valid && !resp_ready |=> resp_valid && $stable(resp_cmd) && $stable(resp_data)
                                    && $stable(resp_dstaddr) && $stable(resp_srcaddr))
   else
   begin
      $display("error %0t: response dropped or changed before it was taken", $time);
      errors = errors + 1;
   end

   one_pending: assert property (@(posedge clk) disable iff (!nreset) resp_valid |-> !req_ready)
   else
   begin
      $display("error %0t: req_ready high with a response pending", $time);
      errors = errors + 1;
   end

   single_pulse: assert property (@(posedge clk) disable iff (!nreset)
      crdt_update |=> !crdt_update)
   else
   begin
      $display("error %0t: crdt_update longer than one cycle", $time);
      errors = errors + 1;
   end

   // pulse counter, sampled mid-cycle
   always @(negedge clk)
   begin
      cycle = cycle + 1;
      if (crdt_update)
      begin
         pulses     = pulses + 1;
         gap        = cycle - last_pulse;
         last_pulse = cycle;
      end
   end

   //######################################################################
   // helpers
   //######################################################################
   task automatic check_value(input string what, input link_pkg::data_t got,
                              input link_pkg::data_t exp);
      checks = checks + 1;
      assert (got === exp)
      else
      begin
         $display("error %0t: %s is %h, expected %h", $time, what, got, exp);
         errors = errors + 1;
      end
   endtask

   task automatic check_flag(input string what, input logic got, input logic exp);
      checks = checks + 1;
      assert (got === exp)
      else
      begin
         $display("error %0t: %s is %b, expected %b", $time, what, got, exp);
         errors = errors + 1;
      end
   endtask

   function automatic link_pkg::addr_t local_addr(input link_pkg::ofs_t ofs);
      return {32'h0, link_pkg::GRP_ID, 16'h0, ofs};
   endfunction

   // one request, one response; call 1 ns after a rising edge
   task automatic bus_xfer(input link_pkg::op_t op, input link_pkg::addr_t dst,
                           input link_pkg::data_t wdata, input bit bp,
                           input link_pkg::op_t exp_op, output link_pkg::data_t rdata);
      link_pkg::cmd_t  cmd;
      link_pkg::addr_t src;
      int              waited;
      int              hold;
      cmd         = {tag[26:0], op};
      src         = {32'h0000_0001, tag};
      tag         = tag + 1;
      rdata       = '0;
      req_cmd     = cmd;
      req_dstaddr = dst;
      req_srcaddr = src;
      req_data    = wdata;
      req_valid   = 1'b1;
      waited      = 0;
      while (!req_ready && waited < WAIT_LIMIT)
      begin
         @(posedge clk);
         #1;
         waited = waited + 1;
      end
      @(posedge clk);   // transfer edge
      #1;
      req_valid = 1'b0;
      waited    = 0;
      while (!resp_valid && waited < WAIT_LIMIT)
      begin
         @(posedge clk);
         #1;
         waited = waited + 1;
      end
      if (!resp_valid)
      begin
         $display("timeout: no response to request %h within %0d cycles", cmd, WAIT_LIMIT);
         errors = errors + 1;
      end
      else
      begin
         check_value("resp_cmd", resp_cmd, {cmd[31:5], exp_op});
         check_flag("resp_dstaddr is request source", resp_dstaddr === src, 1'b1);
         check_flag("resp_srcaddr is request destination", resp_srcaddr === dst, 1'b1);
         rdata = resp_data;
         if (bp)
         begin
            hold      = 1 + {$random(seed)} % 6;
            req_valid = 1'b1;              // second request must wait
            repeat (hold)
            begin
               @(posedge clk);
               #1;
               check_flag("req_ready while pending", req_ready, 1'b0);
               check_value("held resp_data", resp_data, rdata);
            end
            req_valid = 1'b0;
         end
         resp_ready = 1'b1;
         @(posedge clk);
         #1;
         resp_ready = 1'b0;
         check_flag("req_ready after response", req_ready, 1'b1);
      end
   endtask

   task automatic read_reg(input link_pkg::ofs_t ofs, input link_pkg::data_t exp, input bit bp);
      link_pkg::data_t rd;
      bus_xfer(link_pkg::OP_READ, local_addr(ofs), '0, bp, link_pkg::OP_RESP_READ, rd);
      check_value($sformatf("read of offset %h", ofs), rd, exp);
   endtask

   task automatic write_reg(input link_pkg::ofs_t ofs, input link_pkg::data_t wdata);
      link_pkg::data_t rd;
      bus_xfer(link_pkg::OP_WRITE, local_addr(ofs), wdata, 1'b0, link_pkg::OP_RESP_WRITE, rd);
      check_value("write response data", rd, '0);
   endtask

   // returns 1 ns after the edge that follows the next pulse
   task automatic wait_pulse();
      int seen;
      int waited;
      seen   = pulses;
      waited = 0;
      while (pulses == seen && waited < WAIT_LIMIT)
      begin
         @(posedge clk);
         #1;
         waited = waited + 1;
      end
      if (pulses == seen)
      begin
         $display("timeout: no crdt_update pulse within %0d cycles", WAIT_LIMIT);
         errors = errors + 1;
      end
   endtask

   task automatic end_test(input string name);
      $display("test %-12s %0d checks, %0d errors", name, checks - checks_at, errors - errors_at);
      tests     = tests + 1;
      checks_at = checks;
      errors_at = errors;
   endtask

   //######################################################################
   // test sequence
   //######################################################################
   initial
   begin
      link_pkg::data_t rd;
      link_pkg::data_t ctrl_model;
      link_pkg::iow_t  iow;
      link_pkg::crdt_t crdt;
      nreset         = 1'b0;
      devicemode     = 1'b1;           // device side, gated by deviceready
      deviceready    = 1'b0;
      phy_linkactive = 1'b0;
      phy_iow        = '0;
      req_valid      = 1'b0;
      req_cmd        = '0;
      req_dstaddr    = '0;
      req_srcaddr    = '0;
      req_data       = '0;
      resp_ready     = 1'b0;
      ctrl_model     = 32'hA5A5_0020;
      iow            = 8'd2;
      repeat (2) @(posedge clk);
      #1;
      nreset = 1'b1;

      // reset values
      check_flag("req_ready", req_ready, 1'b1);
      check_flag("resp_valid", resp_valid, 1'b0);
      check_flag("crdt_update", crdt_update, 1'b0);
      check_flag("host_linkactive", host_linkactive, 1'b0);
      check_flag("csr_txen", csr_txen, 1'b0);
      check_flag("csr_rxen", csr_rxen, 1'b0);
      read_reg(link_pkg::REG_CTRL, 32'h0, 1'b0);
      read_reg(link_pkg::REG_STATUS, 32'h0, 1'b0);
      read_reg(link_pkg::REG_TXMODE, 32'h0, 1'b0);
      read_reg(link_pkg::REG_RXMODE, 32'h0, 1'b0);
      read_reg(link_pkg::REG_CRDTINIT, 32'h0, 1'b0);
      read_reg(link_pkg::REG_CRDTINTRVL, 32'h0000_00FF, 1'b0);
      end_test("reset");

      // write and readback, status is read only
      write_reg(link_pkg::REG_CTRL, ctrl_model);
      read_reg(link_pkg::REG_CTRL, ctrl_model, 1'b0);
      check_flag("csr_arbmode", csr_arbmode === ctrl_model[5:4], 1'b1);
      write_reg(link_pkg::REG_CRDTINTRVL, 32'h0000_0009);
      read_reg(link_pkg::REG_CRDTINTRVL, 32'h0000_0009, 1'b0);
      check_value("csr_txcrdt_intrvl", {16'h0, csr_txcrdt_intrvl}, 32'h0000_0009);
      write_reg(link_pkg::REG_STATUS, 32'hFFFF_FFFF);
      read_reg(link_pkg::REG_STATUS, 32'h0, 1'b0);
      end_test("readback");

      // link-up held off until the device is ready
      phy_iow        = iow;
      phy_linkactive = 1'b1;
      repeat (4) @(posedge clk);
      #1;
      check_flag("host_linkactive before deviceready", host_linkactive, 1'b0);
      check_flag("csr_txen before deviceready", csr_txen, 1'b0);
      deviceready = 1'b1;
      repeat (WAIT_LIMIT)
      begin
         if (!host_linkactive)
         begin
            @(posedge clk);
            #1;
         end
      end
      check_flag("host_linkactive after deviceready", host_linkactive, 1'b1);
      repeat (2) @(posedge clk);      // auto-load two edges after the rise
      #1;
      crdt = link_pkg::CRDT_TOTAL * (16'd1 << iow);
      check_flag("csr_txen", csr_txen, 1'b1);
      check_flag("csr_rxen", csr_rxen, 1'b1);
      check_flag("csr_txcrdt_en", csr_txcrdt_en, 1'b1);
      check_flag("csr_txiowidth", csr_txiowidth === iow, 1'b1);
      check_flag("csr_rxiowidth", csr_rxiowidth === iow, 1'b1);
      check_flag("csr_rxcrdt_req_init", csr_rxcrdt_req_init === crdt, 1'b1);
      check_flag("csr_rxcrdt_resp_init", csr_rxcrdt_resp_init === crdt, 1'b1);
      read_reg(link_pkg::REG_TXMODE, {8'h00, iow, 16'h0011}, 1'b0);
      read_reg(link_pkg::REG_RXMODE, {8'h00, iow, 16'h0001}, 1'b0);
      read_reg(link_pkg::REG_CRDTINIT, {crdt, crdt}, 1'b0);
      read_reg(link_pkg::REG_STATUS, 32'h0000_0010, 1'b0);
      end_test("linkup");

      // credit timer period and pulse count
      write_reg(link_pkg::REG_CRDTINTRVL, {16'h0, K_INTRVL});
      wait_pulse();                   // old interval may still be loaded
      wait_pulse();
      repeat (3)
      begin
         wait_pulse();
         check_value("cycles between pulses", gap, K_INTRVL + 1);
      end
      bus_xfer(link_pkg::OP_READ, local_addr(link_pkg::REG_CRDTSTAT), '0, 1'b0,
               link_pkg::OP_RESP_READ, rd);
      check_flag("timer running bit", rd[16], 1'b1);
      write_reg(link_pkg::REG_TXMODE, {8'h00, iow, 16'h0001});   // credit updates off
      repeat (3) @(posedge clk);
      #1;
      check_flag("csr_txcrdt_en after disable", csr_txcrdt_en, 1'b0);
      check_flag("csr_txen after disable", csr_txen, 1'b1);
      read_reg(link_pkg::REG_CRDTSTAT, {16'h0000, pulses[15:0]}, 1'b0);
      end_test("timer");

      // error responses and back-pressure
      bus_xfer(link_pkg::OP_WRITE, {32'h0, 8'h3A, 16'h0, link_pkg::REG_CTRL}, 32'hDEAD_BEEF,
               1'b1, link_pkg::OP_RESP_ERR, rd);
      check_value("foreign group data", rd, '0);
      bus_xfer(5'h07, local_addr(link_pkg::REG_CTRL), 32'h1111_1111, 1'b1,
               link_pkg::OP_RESP_ERR, rd);
      check_value("unknown opcode data", rd, '0);
      read_reg(8'h1C, 32'h0, 1'b1);   // unmapped offsets
      read_reg(8'h40, 32'h0, 1'b1);
      read_reg(link_pkg::REG_CTRL, ctrl_model, 1'b1);
      read_reg(link_pkg::REG_CRDTINTRVL, {16'h0, K_INTRVL}, 1'b1);
      read_reg(link_pkg::REG_STATUS, 32'h0000_0010, 1'b1);
      end_test("errors");

      $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
      if (errors == 0)
         $display("sim passed");
      else
         $display("sim failed");
      $finish;
   end

   // watchdog
   initial
   begin
      #(WATCHDOG_NS);
      $display("watchdog: run did not finish within %0d ns", WATCHDOG_NS);
      $display("sim failed");
      $finish;
   end

endmodule

// File: link_ctrl_top.sv
`timescale 1ns/1ps
// control-register block of the link endpoint, register port on one side
// csr outputs and credit-update strobe on the other

module link_ctrl_top
  (
   input  logic            clk,
   input  logic            nreset,
   input  logic            devicemode,
   input  logic            deviceready,
   // register port
   input  logic            req_valid,
   input  link_pkg::cmd_t  req_cmd,
   input  link_pkg::addr_t req_dstaddr,
   input  link_pkg::addr_t req_srcaddr,
   input  link_pkg::data_t req_data,
   output logic            req_ready,
   output logic            resp_valid,
   output link_pkg::cmd_t  resp_cmd,
   output link_pkg::addr_t resp_dstaddr,
   output link_pkg::addr_t resp_srcaddr,
   output link_pkg::data_t resp_data,
   input  logic            resp_ready,
   // phy
   input  logic            phy_linkactive,
   input  link_pkg::iow_t  phy_iow,
   // link controls
   output logic            host_linkactive,
   output logic [1:0]      csr_arbmode,
   output logic            csr_txen,
   output logic            csr_txcrdt_en,
   output link_pkg::iow_t  csr_txiowidth,
   output logic            csr_rxen,
   output link_pkg::iow_t  csr_rxiowidth,
   output link_pkg::crdt_t csr_txcrdt_intrvl,
   output link_pkg::crdt_t csr_rxcrdt_req_init,
   output link_pkg::crdt_t csr_rxcrdt_resp_init,
   output logic            crdt_update
   );

   link_pkg::addr_t reg_addr;
   link_pkg::data_t reg_wrdata;
   link_pkg::data_t reg_rddata;
   link_pkg::data_t txcrdt_status;
   logic            reg_write;
   logic            reg_read;

   //####################################################################
   // register port adapter
   //####################################################################
   link_regif i_regif
     (.clk (clk), .nreset (nreset),
      .req_valid (req_valid), .req_cmd (req_cmd),
      .req_dstaddr (req_dstaddr), .req_srcaddr (req_srcaddr),
      .req_data (req_data), .req_ready (req_ready),
      .resp_valid (resp_valid), .resp_cmd (resp_cmd),
      .resp_dstaddr (resp_dstaddr), .resp_srcaddr (resp_srcaddr),
      .resp_data (resp_data), .resp_ready (resp_ready),
      .reg_addr (reg_addr), .reg_wrdata (reg_wrdata),
      .reg_write (reg_write), .reg_read (reg_read),
      .reg_rddata (reg_rddata));

   // register file
   link_regs i_regs
     (.clk (clk), .nreset (nreset),
      .devicemode (devicemode), .deviceready (deviceready),
      .phy_linkactive (phy_linkactive), .phy_iow (phy_iow),
      .reg_addr (reg_addr), .reg_wrdata (reg_wrdata),
      .reg_write (reg_write), .reg_read (reg_read),
      .reg_rddata (reg_rddata),
      .host_linkactive (host_linkactive), .csr_arbmode (csr_arbmode),
      .csr_txen (csr_txen), .csr_txcrdt_en (csr_txcrdt_en),
      .csr_txiowidth (csr_txiowidth), .csr_rxen (csr_rxen),
      .csr_rxiowidth (csr_rxiowidth), .csr_txcrdt_intrvl (csr_txcrdt_intrvl),
      .csr_rxcrdt_req_init (csr_rxcrdt_req_init),
      .csr_rxcrdt_resp_init (csr_rxcrdt_resp_init),
      .txcrdt_status (txcrdt_status));

   // credit-update timer, runs off the gated tx enable
   link_txcrdt i_txcrdt
     (.clk (clk), .nreset (nreset),
      .txen (csr_txen), .txcrdt_en (csr_txcrdt_en),
      .txcrdt_intrvl (csr_txcrdt_intrvl),
      .crdt_update (crdt_update), .txcrdt_status (txcrdt_status));

endmodule

// File: link_txcrdt.sv
`timescale 1ns/1ps
// pulse period is interval+1 cycles; interval 0 gives a pulse every cycle
// an interval change takes effect at the next reload

module link_txcrdt
  (
   input  logic            clk,
   input  logic            nreset,
   input  logic            txen,           // link tx enabled
   input  logic            txcrdt_en,      // credit updates enabled
   input  link_pkg::crdt_t txcrdt_intrvl,
   output logic            crdt_update,    // one-cycle strobe
   output link_pkg::data_t txcrdt_status
   );

   link_pkg::crdt_t cnt;         // cycles left to next pulse
   link_pkg::crdt_t pulse_cnt;   // wraps, survives disable
   logic            running;
   logic            run_en;

   assign run_en = txen & txcrdt_en;

   //####################################################################
   // interval down-counter
   //####################################################################
   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
      begin
         cnt         <= '0;
         running     <= 1'b0;
         crdt_update <= 1'b0;
         pulse_cnt   <= '0;
      end
      else if (!run_en)
      begin
         cnt         <= '0;            // disable clears the timer only
         running     <= 1'b0;
         crdt_update <= 1'b0;
      end
      else if (!running)
      begin
         cnt         <= txcrdt_intrvl; // first enabled edge arms it
         running     <= 1'b1;
         crdt_update <= 1'b0;
      end
      else if (cnt == '0)
      begin
         cnt         <= txcrdt_intrvl; // expired, reload
         crdt_update <= 1'b1;
         pulse_cnt   <= pulse_cnt + 1'b1;
      end
      else
      begin
         cnt         <= cnt - 1'b1;
         crdt_update <= 1'b0;
      end
   end

   // bit 16 running, low half pulse count
   assign txcrdt_status = {15'd0, running, pulse_cnt};

endmodule

// File: link_regs.sv
`timescale 1ns/1ps
// link mode registers, decoded on addr[7:2] only; upper address bits ignored
// tx/rx mode and credit init reload from the phy on every link-up

module link_regs
  (
   input  logic              clk,
   input  logic              nreset,
   input  logic              devicemode,      // 1 = device side
   input  logic              deviceready,
   input  logic              phy_linkactive,
   input  link_pkg::iow_t    phy_iow,
   // register access
   input  link_pkg::addr_t   reg_addr,
   input  link_pkg::data_t   reg_wrdata,
   input  logic              reg_write,
   input  logic              reg_read,
   output link_pkg::data_t   reg_rddata,
   // link controls
   output logic              host_linkactive,
   output logic [1:0]        csr_arbmode,
   output logic              csr_txen,
   output logic              csr_txcrdt_en,
   output link_pkg::iow_t    csr_txiowidth,
   output logic              csr_rxen,
   output link_pkg::iow_t    csr_rxiowidth,
   output link_pkg::crdt_t   csr_txcrdt_intrvl,
   output link_pkg::crdt_t   csr_rxcrdt_req_init,
   output link_pkg::crdt_t   csr_rxcrdt_resp_init,
   input  link_pkg::data_t   txcrdt_status
   );

   link_pkg::data_t  ctrl_reg;
   link_pkg::data_t  txmode_reg;
   link_pkg::data_t  rxmode_reg;
   link_pkg::data_t  crdtinit_reg;
   link_pkg::crdt_t  intrvl_reg;
   link_pkg::data_t  status_word;
   link_pkg::crdt_t  crdt_load;       // credits for current phy width

   logic             link_active;
   logic             link_active_d;
   logic             link_rise;       // one cycle, delayed by one

   logic             wr_ctrl;
   logic             wr_txmode;
   logic             wr_rxmode;
   logic             wr_crdtinit;
   logic             wr_intrvl;

   //####################################################################
   // link active tracking
   //####################################################################
   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
      begin
         link_active   <= 1'b0;
         link_active_d <= 1'b0;
         link_rise     <= 1'b0;
      end
      else
      begin
         if (!devicemode || deviceready)   // device waits for brick ready
            link_active <= phy_linkactive;
         link_active_d <= link_active;
         link_rise     <= link_active & ~link_active_d;
      end
   end

   assign host_linkactive = link_active;

   // CRDT_TOTAL scaled by 2^iow
   assign crdt_load = link_pkg::crdt_t'(link_pkg::CRDT_TOTAL << phy_iow);

   //####################################################################
   // write decode
   //####################################################################
   assign wr_ctrl     = reg_write & (reg_addr[7:2] == link_pkg::REG_CTRL[7:2]);
   assign wr_txmode   = reg_write & (reg_addr[7:2] == link_pkg::REG_TXMODE[7:2]);
   assign wr_rxmode   = reg_write & (reg_addr[7:2] == link_pkg::REG_RXMODE[7:2]);
   assign wr_crdtinit = reg_write & (reg_addr[7:2] == link_pkg::REG_CRDTINIT[7:2]);
   assign wr_intrvl   = reg_write & (reg_addr[7:2] == link_pkg::REG_CRDTINTRVL[7:2]);

   //####################################################################
   // registers
   //####################################################################
   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
      begin
         ctrl_reg     <= '0;
         txmode_reg   <= '0;
         rxmode_reg   <= '0;
         crdtinit_reg <= '0;
         intrvl_reg   <= link_pkg::INTRVL_RESET;
      end
      else
      begin
         if (wr_ctrl)
            ctrl_reg <= reg_wrdata;
         // link-up load wins over a software write in the same cycle
         if (link_rise)
         begin
            txmode_reg   <= {8'h00, phy_iow, 8'h00, 4'h1, 4'h1};  // crdt en, tx en
            rxmode_reg   <= {8'h00, phy_iow, 12'h000, 4'h1};      // rx en
            crdtinit_reg <= {crdt_load, crdt_load};
         end
         else
         begin
            if (wr_txmode)
               txmode_reg <= reg_wrdata;
            if (wr_rxmode)
               rxmode_reg <= reg_wrdata;
            if (wr_crdtinit)
               crdtinit_reg <= reg_wrdata;
         end
         if (wr_intrvl)
            intrvl_reg <= reg_wrdata[link_pkg::CRDT_W-1:0];
      end
   end

   assign status_word = {27'd0, link_active, 4'h0};   // bit 4 = link up

   //####################################################################
   // read mux, registered
   //####################################################################
   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
         reg_rddata <= '0;
      else if (reg_read)
      begin
         case (reg_addr[7:2])
            link_pkg::REG_CTRL[7:2]       : reg_rddata <= ctrl_reg;
            link_pkg::REG_STATUS[7:2]     : reg_rddata <= status_word;
            link_pkg::REG_TXMODE[7:2]     : reg_rddata <= txmode_reg;
            link_pkg::REG_RXMODE[7:2]     : reg_rddata <= rxmode_reg;
            link_pkg::REG_CRDTINIT[7:2]   : reg_rddata <= crdtinit_reg;
            link_pkg::REG_CRDTINTRVL[7:2] : reg_rddata <= {16'h0000, intrvl_reg};
            link_pkg::REG_CRDTSTAT[7:2]   : reg_rddata <= txcrdt_status;
            default                       : reg_rddata <= '0;   // unmapped
         endcase
      end
   end

   // field outputs
   assign csr_arbmode          = ctrl_reg[5:4];
   assign csr_txen             = link_active & txmode_reg[0];
   assign csr_txcrdt_en        = txmode_reg[4];
   assign csr_txiowidth        = txmode_reg[23:16];
   assign csr_rxen             = link_active & rxmode_reg[0];
   assign csr_rxiowidth        = rxmode_reg[23:16];
   assign csr_txcrdt_intrvl    = intrvl_reg;
   assign csr_rxcrdt_req_init  = crdtinit_reg[15:0];
   assign csr_rxcrdt_resp_init = crdtinit_reg[31:16];

endmodule

// File: link_regif.sv
`timescale 1ns/1ps
// single outstanding transaction, single-beat 32-bit accesses only
// foreign group or unknown opcode answers OP_RESP_ERR with zero data

module link_regif
  (
   input  logic            clk,
   input  logic            nreset,
   // request side
   input  logic            req_valid,
   input  link_pkg::cmd_t  req_cmd,
   input  link_pkg::addr_t req_dstaddr,
   input  link_pkg::addr_t req_srcaddr,
   input  link_pkg::data_t req_data,
   output logic            req_ready,
   // response side
   output logic            resp_valid,
   output link_pkg::cmd_t  resp_cmd,
   output link_pkg::addr_t resp_dstaddr,
   output link_pkg::addr_t resp_srcaddr,
   output link_pkg::data_t resp_data,
   input  logic            resp_ready,
   // register access strobes
   output link_pkg::addr_t reg_addr,
   output link_pkg::data_t reg_wrdata,
   output logic            reg_write,
   output logic            reg_read,
   input  link_pkg::data_t reg_rddata
   );

   link_pkg::regif_state_e state;

   link_pkg::cmd_t  cmd_q;             // latched request payload
   link_pkg::addr_t dst_q;
   link_pkg::addr_t src_q;
   link_pkg::data_t data_q;

   logic            hit_read;          // decoded at accept
   logic            hit_write;
   logic            grp_match;
   logic            accept;
   link_pkg::op_t   req_op;
   link_pkg::op_t   resp_op;

   //####################################################################
   // request decode
   //####################################################################
   assign req_op    = req_cmd[link_pkg::OP_W-1:0];
   assign grp_match = (req_dstaddr[link_pkg::GRP_OFFSET +: link_pkg::GRP_W]
                       == link_pkg::GRP_ID);
   assign req_ready = (state == link_pkg::IDLE);   // one in flight
   assign accept    = req_valid & req_ready;

   //####################################################################
   // control fsm
   //####################################################################
   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
      begin
         state      <= link_pkg::IDLE;
         resp_valid <= 1'b0;
         hit_read   <= 1'b0;
         hit_write  <= 1'b0;
      end
      else
      begin
         case (state)
            link_pkg::IDLE:
            begin
               if (accept)
               begin
                  hit_read  <= grp_match & (req_op == link_pkg::OP_READ);
                  hit_write <= grp_match & (req_op == link_pkg::OP_WRITE);
                  state     <= link_pkg::ACCESS;
               end
            end
            link_pkg::ACCESS:
               state <= link_pkg::RESPOND;   // strobe cycle done
            link_pkg::RESPOND:
            begin
               if (!resp_valid)
                  resp_valid <= 1'b1;        // rddata is settled now
               else if (resp_ready)
               begin
                  resp_valid <= 1'b0;
                  state      <= link_pkg::IDLE;
               end
            end
            default:
               state <= link_pkg::IDLE;
         endcase
      end
   end

   // payload capture
   always_ff @(posedge clk)
   begin
      if (accept)
      begin
         cmd_q  <= req_cmd;
         dst_q  <= req_dstaddr;
         src_q  <= req_srcaddr;
         data_q <= req_data;
      end
      if ((state == link_pkg::RESPOND) && !resp_valid)
         resp_data <= hit_read ? reg_rddata : '0;   // zero for write/err
   end

   //####################################################################
   // strobes and response fields
   //####################################################################
   assign reg_addr   = dst_q;
   assign reg_wrdata = data_q;
   assign reg_read   = (state == link_pkg::ACCESS) & hit_read;
   assign reg_write  = (state == link_pkg::ACCESS) & hit_write;

   assign resp_op = hit_read  ? link_pkg::OP_RESP_READ  :
                    hit_write ? link_pkg::OP_RESP_WRITE :
                                link_pkg::OP_RESP_ERR;

   // upper cmd bits echoed back
   assign resp_cmd     = {cmd_q[link_pkg::CMD_W-1:link_pkg::OP_W], resp_op};
   assign resp_dstaddr = src_q;        // swapped
   assign resp_srcaddr = dst_q;

endmodule

// File: link_pkg.sv
// shared widths, encodings and register map of the link control block
// group ID and all widths are fixed here, so nothing is set per instance

package link_pkg;

   //####################################################################
   // widths
   //####################################################################
   localparam int CMD_W  = 32;         // command word
   localparam int ADDR_W = 64;         // dst/src address
   localparam int DATA_W = 32;         // register data
   localparam int IOW_W  = 8;          // phy width code
   localparam int CRDT_W = 16;         // credit count / interval
   localparam int OP_W   = 5;          // opcode field in cmd[4:0]
   localparam int GRP_W  = 8;          // group field in dstaddr
   localparam int OFS_W  = 8;          // register offset field

   typedef logic [CMD_W-1:0]  cmd_t;
   typedef logic [ADDR_W-1:0] addr_t;
   typedef logic [DATA_W-1:0] data_t;
   typedef logic [IOW_W-1:0]  iow_t;  // code n = 2^n bytes
   typedef logic [CRDT_W-1:0] crdt_t;
   typedef logic [OP_W-1:0]   op_t;
   typedef logic [OFS_W-1:0]  ofs_t;

   //####################################################################
   // opcodes
   //####################################################################
   localparam op_t OP_READ       = 5'h01;
   localparam op_t OP_RESP_READ  = 5'h02;  // carries data
   localparam op_t OP_WRITE      = 5'h03;
   localparam op_t OP_RESP_WRITE = 5'h04;  // plain ack
   localparam op_t OP_RESP_ERR   = 5'h0F;  // bad opcode or foreign group

   // group decode
   localparam int               GRP_OFFSET = 24;     // lsb of group field
   localparam logic [GRP_W-1:0] GRP_ID     = 8'h0C;

   //####################################################################
   // register map, decoded on addr[7:2]
   //####################################################################
   localparam ofs_t REG_CTRL       = 8'h00;
   localparam ofs_t REG_STATUS     = 8'h04;  // read only
   localparam ofs_t REG_TXMODE     = 8'h08;
   localparam ofs_t REG_RXMODE     = 8'h0C;
   localparam ofs_t REG_CRDTINIT   = 8'h10;
   localparam ofs_t REG_CRDTINTRVL = 8'h14;
   localparam ofs_t REG_CRDTSTAT   = 8'h18;  // read only

   localparam crdt_t CRDT_TOTAL   = 16'd24;   // rx credits per width unit
   localparam crdt_t INTRVL_RESET = 16'h00FF;

   // register port adapter states
   typedef enum logic [1:0]
   {
      IDLE,
      ACCESS,
      RESPOND
   } regif_state_e;

endpackage
